// File: mem_xbar_pkg.sv
package mem_xbar_pkg;

  // Message widths
  localparam int ADDR_W    = 40;
  localparam int DATA_W    = 64;
  localparam int NUM_PORTS = 3;
  localparam int SRC_W     = 2;

  // Local memory map
  localparam logic [ADDR_W-1:0] DRAM_BASE = 40'h00_8000_0000;

  // Device field of a local address
  localparam int DEV_LSB = 20;
  localparam int DEV_W   = 4;

  localparam logic [DEV_W-1:0] DEV_BOOT = 4'd0;
  localparam logic [DEV_W-1:0] DEV_HOST = 4'd1;
  localparam logic [DEV_W-1:0] DEV_CFG  = 4'd2;

  // Register index inside the configuration block, 8 bytes per register
  localparam int CFG_REG_LSB  = 3;
  localparam int CFG_IDX_W    = 2;
  localparam int CFG_NUM_REGS = 4;

  // Message opcode
  typedef enum logic
  {
    OP_RD = 1'b0,
    OP_WR = 1'b1
  } mem_op_e;

  // Decoded destination of a command
  typedef enum logic [1:0]
  {
    DEST_CFG  = 2'd0,
    DEST_IO   = 2'd1,
    DEST_MEM  = 2'd2,
    DEST_LOOP = 2'd3
  } dest_e;

endpackage

// File: two_entry_fifo.sv
`timescale 1ns/1ps

module two_entry_fifo
  import mem_xbar_pkg::*;
  (  input                      clk_i
   , input                      rst_n_i

   , input                      in_v_i
   , output logic               in_ready_o
   , input  mem_op_e            in_op_i
   , input  [ADDR_W-1:0]        in_addr_i
   , input  [DATA_W-1:0]        in_data_i
   , input  [SRC_W-1:0]         in_src_i

   , output logic               out_v_o
   , input                      out_yumi_i
   , output mem_op_e            out_op_o
   , output logic [ADDR_W-1:0]  out_addr_o
   , output logic [DATA_W-1:0]  out_data_o
   , output logic [SRC_W-1:0]   out_src_o
   );

  mem_op_e           slot_op_q   [2];
  logic [ADDR_W-1:0] slot_addr_q [2];
  logic [DATA_W-1:0] slot_data_q [2];
  logic [SRC_W-1:0]  slot_src_q  [2];

  logic wr_ptr_q, rd_ptr_q;
  logic full_q, empty_q;
  logic enq, deq;

  assign in_ready_o = ~full_q;
  assign out_v_o    = ~empty_q;

  assign enq = in_v_i & ~full_q;
  assign deq = out_yumi_i & ~empty_q;

  assign out_op_o   = slot_op_q[rd_ptr_q];
  assign out_addr_o = slot_addr_q[rd_ptr_q];
  assign out_data_o = slot_data_q[rd_ptr_q];
  assign out_src_o  = slot_src_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      full_q   <= 1'b0;
      empty_q  <= 1'b1;
    end
    else
    begin
      if (enq)
        wr_ptr_q <= ~wr_ptr_q;
      if (deq)
        rd_ptr_q <= ~rd_ptr_q;
      // Occupancy only moves when exactly one side transfers
      if (enq && !deq)
      begin
        empty_q <= 1'b0;
        full_q  <= (wr_ptr_q != rd_ptr_q);
      end
      else if (deq && !enq)
      begin
        full_q  <= 1'b0;
        empty_q <= (rd_ptr_q != wr_ptr_q);
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
    begin
      slot_op_q[wr_ptr_q]   <= in_op_i;
      slot_addr_q[wr_ptr_q] <= in_addr_i;
      slot_data_q[wr_ptr_q] <= in_data_i;
      slot_src_q[wr_ptr_q]  <= in_src_i;
    end
  end

endmodule

// File: cmd_dispatch.sv
`timescale 1ns/1ps

module cmd_dispatch
  import mem_xbar_pkg::*;
  (  input  [NUM_PORTS-1:0]              head_v_i
   , input  mem_op_e [NUM_PORTS-1:0]     head_op_i
   , input  [NUM_PORTS-1:0][ADDR_W-1:0]  head_addr_i
   , input  [NUM_PORTS-1:0][DATA_W-1:0]  head_data_i

   , input                               cfg_ready_i
   , input                               loop_ready_i
   , input                               io_ready_i
   , input                               mem_ready_i

   , output logic [NUM_PORTS-1:0]        grant_o

   , output mem_op_e                     cmd_op_o
   , output logic [ADDR_W-1:0]           cmd_addr_o
   , output logic [DATA_W-1:0]           cmd_data_o
   , output logic [SRC_W-1:0]            cmd_src_o

   , output logic                        cfg_v_o
   , output logic                        loop_v_o
   , output logic                        io_v_o
   , output logic                        mem_v_o
   );

  logic              all_ready;
  logic              any_grant;
  logic [SRC_W-1:0]  sel_idx;
  logic [DEV_W-1:0]  dev_code;
  dest_e             dest;

  // A single stalled destination holds back every port
  assign all_ready = cfg_ready_i & loop_ready_i & io_ready_i & mem_ready_i;

  // Lowest index wins, so scan from the top down
  always_comb
  begin
    sel_idx = '0;
    for (int p = NUM_PORTS - 1; p >= 0; p--)
    begin
      if (head_v_i[p])
        sel_idx = SRC_W'(p);
    end
  end

  always_comb
  begin
    grant_o = '0;
    if ((|head_v_i) && all_ready)
      grant_o[sel_idx] = 1'b1;
  end

  assign any_grant = |grant_o;

  assign cmd_op_o   = head_op_i[sel_idx];
  assign cmd_addr_o = head_addr_i[sel_idx];
  assign cmd_data_o = head_data_i[sel_idx];
  assign cmd_src_o  = sel_idx;

  // Local memory map
  assign dev_code = cmd_addr_o[DEV_LSB +: DEV_W];

  always_comb
  begin
    if (cmd_addr_o >= DRAM_BASE)
      dest = DEST_MEM;
    else if (dev_code == DEV_CFG)
      dest = DEST_CFG;
    else if ((dev_code == DEV_BOOT) || (dev_code == DEV_HOST))
      dest = DEST_IO;
    else
      dest = DEST_LOOP;
  end

  assign cfg_v_o  = any_grant & (dest == DEST_CFG);
  assign io_v_o   = any_grant & (dest == DEST_IO);
  assign mem_v_o  = any_grant & (dest == DEST_MEM);
  assign loop_v_o = any_grant & (dest == DEST_LOOP);

endmodule

// File: resp_router.sv
`timescale 1ns/1ps

module resp_router
  import mem_xbar_pkg::*;
  (  input                        cfg_v_i
   , input  mem_op_e              cfg_op_i
   , input  [ADDR_W-1:0]          cfg_addr_i
   , input  [DATA_W-1:0]          cfg_data_i
   , input  [SRC_W-1:0]           cfg_src_i
   , output logic                 cfg_yumi_o

   , input                        io_v_i
   , input  mem_op_e              io_op_i
   , input  [ADDR_W-1:0]          io_addr_i
   , input  [DATA_W-1:0]          io_data_i
   , input  [SRC_W-1:0]           io_src_i
   , output logic                 io_yumi_o

   , input                        mem_v_i
   , input  mem_op_e              mem_op_i
   , input  [ADDR_W-1:0]          mem_addr_i
   , input  [DATA_W-1:0]          mem_data_i
   , input  [SRC_W-1:0]           mem_src_i
   , output logic                 mem_yumi_o

   , input                        loop_v_i
   , input  mem_op_e              loop_op_i
   , input  [ADDR_W-1:0]          loop_addr_i
   , input  [DATA_W-1:0]          loop_data_i
   , input  [SRC_W-1:0]           loop_src_i
   , output logic                 loop_yumi_o

   , input  [NUM_PORTS-1:0]       q_ready_i
   , output logic [NUM_PORTS-1:0] q_v_o
   , output mem_op_e              resp_op_o
   , output logic [ADDR_W-1:0]    resp_addr_o
   , output logic [DATA_W-1:0]    resp_data_o
   );

  logic             all_ready;
  logic             any_yumi;
  logic [SRC_W-1:0] resp_src;

  // Wait for room in every queue, whichever one the response targets
  assign all_ready = &q_ready_i;

  assign cfg_yumi_o  = all_ready & cfg_v_i;
  assign io_yumi_o   = all_ready & io_v_i & ~cfg_v_i;
  assign mem_yumi_o  = all_ready & mem_v_i & ~cfg_v_i & ~io_v_i;
  assign loop_yumi_o = all_ready & loop_v_i & ~cfg_v_i & ~io_v_i & ~mem_v_i;

  assign any_yumi = cfg_yumi_o | io_yumi_o | mem_yumi_o | loop_yumi_o;

  always_comb
  begin
    if (cfg_v_i)
      {resp_op_o, resp_addr_o, resp_data_o, resp_src} = {cfg_op_i, cfg_addr_i, cfg_data_i, cfg_src_i};
    else if (io_v_i)
      {resp_op_o, resp_addr_o, resp_data_o, resp_src} = {io_op_i, io_addr_i, io_data_i, io_src_i};
    else if (mem_v_i)
      {resp_op_o, resp_addr_o, resp_data_o, resp_src} = {mem_op_i, mem_addr_i, mem_data_i, mem_src_i};
    else
      {resp_op_o, resp_addr_o, resp_data_o, resp_src} =
        {loop_op_i, loop_addr_i, loop_data_i, loop_src_i};
  end

  // Steer back to the issuing port
  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : steer
    assign q_v_o[i] = any_yumi & (resp_src == SRC_W'(i));
  end

endmodule

// File: cfg_regs.sv
`timescale 1ns/1ps

module cfg_regs
  import mem_xbar_pkg::*;
  (  input                      clk_i
   , input                      rst_n_i

   , input                      cmd_v_i
   , output logic               cmd_ready_o
   , input  mem_op_e            cmd_op_i
   , input  [ADDR_W-1:0]        cmd_addr_i
   , input  [DATA_W-1:0]        cmd_data_i
   , input  [SRC_W-1:0]         cmd_src_i

   , output logic               resp_v_o
   , input                      resp_yumi_i
   , output mem_op_e            resp_op_o
   , output logic [ADDR_W-1:0]  resp_addr_o
   , output logic [DATA_W-1:0]  resp_data_o
   , output logic [SRC_W-1:0]   resp_src_o
   );

  logic [DATA_W-1:0]    regs_q [CFG_NUM_REGS];
  logic [CFG_IDX_W-1:0] reg_idx;
  logic                 accept;

  assign reg_idx     = cmd_addr_i[CFG_REG_LSB +: CFG_IDX_W];
  assign cmd_ready_o = ~resp_v_o;
  assign accept      = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      resp_v_o <= 1'b0;
      for (int r = 0; r < CFG_NUM_REGS; r++)
        regs_q[r] <= '0;
    end
    else
    begin
      if (accept)
        resp_v_o <= 1'b1;
      else if (resp_yumi_i)
        resp_v_o <= 1'b0;
      if (accept && (cmd_op_i == OP_WR))
        regs_q[reg_idx] <= cmd_data_i;
    end
  end

  // Write acks carry zero data
  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_op_o   <= cmd_op_i;
      resp_addr_o <= cmd_addr_i;
      resp_src_o  <= cmd_src_i;
      resp_data_o <= (cmd_op_i == OP_RD) ? regs_q[reg_idx] : '0;
    end
  end

endmodule

// File: loopback_dev.sv
`timescale 1ns/1ps

module loopback_dev
  import mem_xbar_pkg::*;
  (  input                      clk_i
   , input                      rst_n_i

   , input                      cmd_v_i
   , output logic               cmd_ready_o
   , input  mem_op_e            cmd_op_i
   , input  [ADDR_W-1:0]        cmd_addr_i
   , input  [DATA_W-1:0]        cmd_data_i
   , input  [SRC_W-1:0]         cmd_src_i

   , output logic               resp_v_o
   , input                      resp_yumi_i
   , output mem_op_e            resp_op_o
   , output logic [ADDR_W-1:0]  resp_addr_o
   , output logic [DATA_W-1:0]  resp_data_o
   , output logic [SRC_W-1:0]   resp_src_o
   );

  logic accept;

  assign cmd_ready_o = ~resp_v_o;
  assign accept      = cmd_v_i & cmd_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      resp_v_o <= 1'b0;
    else if (accept)
      resp_v_o <= 1'b1;
    else if (resp_yumi_i)
      resp_v_o <= 1'b0;
  end

  // Unmapped space reads as zero and swallows writes
  assign resp_data_o = '0;

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      resp_op_o   <= cmd_op_i;
      resp_addr_o <= cmd_addr_i;
      resp_src_o  <= cmd_src_i;
    end
  end

endmodule

// File: mem_xbar_top.sv
`timescale 1ns/1ps

module mem_xbar_top
  import mem_xbar_pkg::*;
  (  input                                     clk_i
   , input                                     rst_n_i

   // Requester ports
   , input  [NUM_PORTS-1:0]                    req_cmd_v_i
   , output logic [NUM_PORTS-1:0]              req_cmd_ready_o
   , input  mem_op_e [NUM_PORTS-1:0]           req_cmd_op_i
   , input  [NUM_PORTS-1:0][ADDR_W-1:0]        req_cmd_addr_i
   , input  [NUM_PORTS-1:0][DATA_W-1:0]        req_cmd_data_i

   , output logic [NUM_PORTS-1:0]              req_resp_v_o
   , input  [NUM_PORTS-1:0]                    req_resp_yumi_i
   , output mem_op_e [NUM_PORTS-1:0]           req_resp_op_o
   , output logic [NUM_PORTS-1:0][ADDR_W-1:0]  req_resp_addr_o
   , output logic [NUM_PORTS-1:0][DATA_W-1:0]  req_resp_data_o

   // Outgoing I/O
   , output logic                              io_cmd_v_o
   , input                                     io_cmd_ready_i
   , output mem_op_e                           io_cmd_op_o
   , output logic [ADDR_W-1:0]                 io_cmd_addr_o
   , output logic [DATA_W-1:0]                 io_cmd_data_o
   , output logic [SRC_W-1:0]                  io_cmd_src_o

   , input                                     io_resp_v_i
   , output logic                              io_resp_yumi_o
   , input  mem_op_e                           io_resp_op_i
   , input  [ADDR_W-1:0]                       io_resp_addr_i
   , input  [DATA_W-1:0]                       io_resp_data_i
   , input  [SRC_W-1:0]                        io_resp_src_i

   // Main memory
   , output logic                              mem_cmd_v_o
   , input                                     mem_cmd_ready_i
   , output mem_op_e                           mem_cmd_op_o
   , output logic [ADDR_W-1:0]                 mem_cmd_addr_o
   , output logic [DATA_W-1:0]                 mem_cmd_data_o
   , output logic [SRC_W-1:0]                  mem_cmd_src_o

   , input                                     mem_resp_v_i
   , output logic                              mem_resp_yumi_o
   , input  mem_op_e                           mem_resp_op_i
   , input  [ADDR_W-1:0]                       mem_resp_addr_i
   , input  [DATA_W-1:0]                       mem_resp_data_i
   , input  [SRC_W-1:0]                        mem_resp_src_i
   );

  // Queue heads toward the dispatcher
  logic [NUM_PORTS-1:0]             head_v, head_yumi;
  mem_op_e [NUM_PORTS-1:0]          head_op;
  logic [NUM_PORTS-1:0][ADDR_W-1:0] head_addr;
  logic [NUM_PORTS-1:0][DATA_W-1:0] head_data;

  // Routed response toward the response queues
  logic [NUM_PORTS-1:0] rq_v, rq_ready;
  mem_op_e              rq_op;
  logic [ADDR_W-1:0]    rq_addr;
  logic [DATA_W-1:0]    rq_data;

  // Dispatched command, broadcast to every device
  mem_op_e           cmd_op;
  logic [ADDR_W-1:0] cmd_addr;
  logic [DATA_W-1:0] cmd_data;
  logic [SRC_W-1:0]  cmd_src;

  logic cfg_cmd_v, cfg_cmd_ready, loop_cmd_v, loop_cmd_ready;

  logic              cfg_resp_v, cfg_resp_yumi;
  mem_op_e           cfg_resp_op;
  logic [ADDR_W-1:0] cfg_resp_addr;
  logic [DATA_W-1:0] cfg_resp_data;
  logic [SRC_W-1:0]  cfg_resp_src;

  logic              loop_resp_v, loop_resp_yumi;
  mem_op_e           loop_resp_op;
  logic [ADDR_W-1:0] loop_resp_addr;
  logic [DATA_W-1:0] loop_resp_data;
  logic [SRC_W-1:0]  loop_resp_src;

  for (genvar i = 0; i < NUM_PORTS; i++)
  begin : fifo
    two_entry_fifo cmd_fifo
      (.clk_i      (clk_i)
      ,.rst_n_i    (rst_n_i)
      ,.in_v_i     (req_cmd_v_i[i])
      ,.in_ready_o (req_cmd_ready_o[i])
      ,.in_op_i    (req_cmd_op_i[i])
      ,.in_addr_i  (req_cmd_addr_i[i])
      ,.in_data_i  (req_cmd_data_i[i])
      ,.in_src_i   (SRC_W'(i))
      ,.out_v_o    (head_v[i])
      ,.out_yumi_i (head_yumi[i])
      ,.out_op_o   (head_op[i])
      ,.out_addr_o (head_addr[i])
      ,.out_data_o (head_data[i])
      ,.out_src_o  ()
      );

    two_entry_fifo resp_fifo
      (.clk_i      (clk_i)
      ,.rst_n_i    (rst_n_i)
      ,.in_v_i     (rq_v[i])
      ,.in_ready_o (rq_ready[i])
      ,.in_op_i    (rq_op)
      ,.in_addr_i  (rq_addr)
      ,.in_data_i  (rq_data)
      ,.in_src_i   (SRC_W'(i))
      ,.out_v_o    (req_resp_v_o[i])
      ,.out_yumi_i (req_resp_yumi_i[i])
      ,.out_op_o   (req_resp_op_o[i])
      ,.out_addr_o (req_resp_addr_o[i])
      ,.out_data_o (req_resp_data_o[i])
      ,.out_src_o  ()
      );
  end

  cmd_dispatch dispatch
    (.head_v_i     (head_v)
    ,.head_op_i    (head_op)
    ,.head_addr_i  (head_addr)
    ,.head_data_i  (head_data)
    ,.cfg_ready_i  (cfg_cmd_ready)
    ,.loop_ready_i (loop_cmd_ready)
    ,.io_ready_i   (io_cmd_ready_i)
    ,.mem_ready_i  (mem_cmd_ready_i)
    ,.grant_o      (head_yumi)
    ,.cmd_op_o     (cmd_op)
    ,.cmd_addr_o   (cmd_addr)
    ,.cmd_data_o   (cmd_data)
    ,.cmd_src_o    (cmd_src)
    ,.cfg_v_o      (cfg_cmd_v)
    ,.loop_v_o     (loop_cmd_v)
    ,.io_v_o       (io_cmd_v_o)
    ,.mem_v_o      (mem_cmd_v_o)
    );

  assign {io_cmd_op_o, io_cmd_addr_o, io_cmd_data_o, io_cmd_src_o} =
    {cmd_op, cmd_addr, cmd_data, cmd_src};
  assign {mem_cmd_op_o, mem_cmd_addr_o, mem_cmd_data_o, mem_cmd_src_o} =
    {cmd_op, cmd_addr, cmd_data, cmd_src};

  cfg_regs cfg
    (.clk_i       (clk_i)
    ,.rst_n_i     (rst_n_i)
    ,.cmd_v_i     (cfg_cmd_v)
    ,.cmd_ready_o (cfg_cmd_ready)
    ,.cmd_op_i    (cmd_op)
    ,.cmd_addr_i  (cmd_addr)
    ,.cmd_data_i  (cmd_data)
    ,.cmd_src_i   (cmd_src)
    ,.resp_v_o    (cfg_resp_v)
    ,.resp_yumi_i (cfg_resp_yumi)
    ,.resp_op_o   (cfg_resp_op)
    ,.resp_addr_o (cfg_resp_addr)
    ,.resp_data_o (cfg_resp_data)
    ,.resp_src_o  (cfg_resp_src)
    );

  loopback_dev loopback
    (.clk_i       (clk_i)
    ,.rst_n_i     (rst_n_i)
    ,.cmd_v_i     (loop_cmd_v)
    ,.cmd_ready_o (loop_cmd_ready)
    ,.cmd_op_i    (cmd_op)
    ,.cmd_addr_i  (cmd_addr)
    ,.cmd_data_i  (cmd_data)
    ,.cmd_src_i   (cmd_src)
    ,.resp_v_o    (loop_resp_v)
    ,.resp_yumi_i (loop_resp_yumi)
    ,.resp_op_o   (loop_resp_op)
    ,.resp_addr_o (loop_resp_addr)
    ,.resp_data_o (loop_resp_data)
    ,.resp_src_o  (loop_resp_src)
    );

  resp_router router
    (.cfg_v_i     (cfg_resp_v)
    ,.cfg_op_i    (cfg_resp_op)
    ,.cfg_addr_i  (cfg_resp_addr)
    ,.cfg_data_i  (cfg_resp_data)
    ,.cfg_src_i   (cfg_resp_src)
    ,.cfg_yumi_o  (cfg_resp_yumi)
    ,.io_v_i      (io_resp_v_i)
    ,.io_op_i     (io_resp_op_i)
    ,.io_addr_i   (io_resp_addr_i)
    ,.io_data_i   (io_resp_data_i)
    ,.io_src_i    (io_resp_src_i)
    ,.io_yumi_o   (io_resp_yumi_o)
    ,.mem_v_i     (mem_resp_v_i)
    ,.mem_op_i    (mem_resp_op_i)
    ,.mem_addr_i  (mem_resp_addr_i)
    ,.mem_data_i  (mem_resp_data_i)
    ,.mem_src_i   (mem_resp_src_i)
    ,.mem_yumi_o  (mem_resp_yumi_o)
    ,.loop_v_i    (loop_resp_v)
    ,.loop_op_i   (loop_resp_op)
    ,.loop_addr_i (loop_resp_addr)
    ,.loop_data_i (loop_resp_data)
    ,.loop_src_i  (loop_resp_src)
    ,.loop_yumi_o (loop_resp_yumi)
    ,.q_ready_i   (rq_ready)
    ,.q_v_o       (rq_v)
    ,.resp_op_o   (rq_op)
    ,.resp_addr_o (rq_addr)
    ,.resp_data_o (rq_data)
    );

endmodule

// File: tb_mem_xbar.sv
`timescale 1ns/1ps

// Stands in for main memory or the I/O bus and answers commands in arrival order
module ext_responder
  import mem_xbar_pkg::*;
  #(parameter logic [DATA_W-1:0] READ_KEY = '0)
  (  input                      clk_i
   , input                      cmd_v_i
   , input                      cmd_ready_i
   , input  mem_op_e            cmd_op_i
   , input  [ADDR_W-1:0]        cmd_addr_i
   , input  [SRC_W-1:0]         cmd_src_i
   , output logic               resp_v_o
   , input                      resp_yumi_i
   , output mem_op_e            resp_op_o
   , output logic [ADDR_W-1:0]  resp_addr_o
   , output logic [DATA_W-1:0]  resp_data_o
   , output logic [SRC_W-1:0]   resp_src_o
   );

  mem_op_e           op_q   [$];
  logic [ADDR_W-1:0] addr_q [$];
  logic [SRC_W-1:0]  src_q  [$];

  initial
  begin
    resp_v_o    = 1'b0;
    resp_op_o   = OP_RD;
    resp_addr_o = '0;
    resp_data_o = '0;
    resp_src_o  = '0;
    forever
    begin
      @(negedge clk_i);
      if (cmd_v_i && cmd_ready_i)
      begin
        op_q.push_back(cmd_op_i);
        addr_q.push_back(cmd_addr_i);
        src_q.push_back(cmd_src_i);
      end
      if (resp_v_o && resp_yumi_i)
      begin
        void'(op_q.pop_front());
        void'(addr_q.pop_front());
        void'(src_q.pop_front());
      end
      @(posedge clk_i);
      if (op_q.size() > 0)
      begin
        resp_v_o    <= 1'b1;
        resp_op_o   <= op_q[0];
        resp_addr_o <= addr_q[0];
        resp_src_o  <= src_q[0];
        resp_data_o <= (op_q[0] == OP_RD) ? (DATA_W'(addr_q[0]) ^ READ_KEY) : '0;
      end
      else
        resp_v_o <= 1'b0;
    end
  end

endmodule

module tb_mem_xbar
  import mem_xbar_pkg::*;
  ();

  localparam int                TIMEOUT  = 200;
  localparam logic [DATA_W-1:0] RESP_KEY = 64'h5A5A_C3C3_0F0F_9696;

  logic clk, rst_n;

  logic [NUM_PORTS-1:0]             cmd_v, cmd_ready, resp_v, resp_yumi;
  mem_op_e [NUM_PORTS-1:0]          cmd_op, resp_op;
  logic [NUM_PORTS-1:0][ADDR_W-1:0] cmd_addr, resp_addr;
  logic [NUM_PORTS-1:0][DATA_W-1:0] cmd_data, resp_data;

  logic              io_cmd_v, io_cmd_ready, mem_cmd_v, mem_cmd_ready;
  mem_op_e           io_cmd_op, mem_cmd_op;
  logic [ADDR_W-1:0] io_cmd_addr, mem_cmd_addr;
  logic [DATA_W-1:0] io_cmd_data, mem_cmd_data;
  logic [SRC_W-1:0]  io_cmd_src, mem_cmd_src;

  logic              io_resp_v, io_resp_yumi, mem_resp_v, mem_resp_yumi;
  mem_op_e           io_resp_op, mem_resp_op;
  logic [ADDR_W-1:0] io_resp_addr, mem_resp_addr;
  logic [DATA_W-1:0] io_resp_data, mem_resp_data;
  logic [SRC_W-1:0]  io_resp_src, mem_resp_src;

  logic [15:0]                    lfsr_state;
  logic [DATA_W-1:0]              cfg_model [CFG_NUM_REGS];
  // Each entry is {data, source id, address} as seen on the outgoing port
  logic [DATA_W+SRC_W+ADDR_W-1:0] mem_log [$];
  logic [DATA_W+SRC_W+ADDR_W-1:0] io_log  [$];

  mem_xbar_top DUT
    (.clk_i (clk), .rst_n_i (rst_n)
    ,.req_cmd_v_i (cmd_v), .req_cmd_ready_o (cmd_ready), .req_cmd_op_i (cmd_op)
    ,.req_cmd_addr_i (cmd_addr), .req_cmd_data_i (cmd_data)
    ,.req_resp_v_o (resp_v), .req_resp_yumi_i (resp_yumi), .req_resp_op_o (resp_op)
    ,.req_resp_addr_o (resp_addr), .req_resp_data_o (resp_data)
    ,.io_cmd_v_o (io_cmd_v), .io_cmd_ready_i (io_cmd_ready), .io_cmd_op_o (io_cmd_op)
    ,.io_cmd_addr_o (io_cmd_addr), .io_cmd_data_o (io_cmd_data), .io_cmd_src_o (io_cmd_src)
    ,.io_resp_v_i (io_resp_v), .io_resp_yumi_o (io_resp_yumi), .io_resp_op_i (io_resp_op)
    ,.io_resp_addr_i (io_resp_addr), .io_resp_data_i (io_resp_data), .io_resp_src_i (io_resp_src)
    ,.mem_cmd_v_o (mem_cmd_v), .mem_cmd_ready_i (mem_cmd_ready), .mem_cmd_op_o (mem_cmd_op)
    ,.mem_cmd_addr_o (mem_cmd_addr), .mem_cmd_data_o (mem_cmd_data), .mem_cmd_src_o (mem_cmd_src)
    ,.mem_resp_v_i (mem_resp_v), .mem_resp_yumi_o (mem_resp_yumi), .mem_resp_op_i (mem_resp_op)
    ,.mem_resp_addr_i (mem_resp_addr), .mem_resp_data_i (mem_resp_data)
    ,.mem_resp_src_i (mem_resp_src)
    );

  ext_responder #(.READ_KEY (RESP_KEY)) mem_side
    (.clk_i (clk), .cmd_v_i (mem_cmd_v), .cmd_ready_i (mem_cmd_ready), .cmd_op_i (mem_cmd_op)
    ,.cmd_addr_i (mem_cmd_addr), .cmd_src_i (mem_cmd_src), .resp_v_o (mem_resp_v)
    ,.resp_yumi_i (mem_resp_yumi), .resp_op_o (mem_resp_op), .resp_addr_o (mem_resp_addr)
    ,.resp_data_o (mem_resp_data), .resp_src_o (mem_resp_src)
    );

  ext_responder #(.READ_KEY (RESP_KEY)) io_side
    (.clk_i (clk), .cmd_v_i (io_cmd_v), .cmd_ready_i (io_cmd_ready), .cmd_op_i (io_cmd_op)
    ,.cmd_addr_i (io_cmd_addr), .cmd_src_i (io_cmd_src), .resp_v_o (io_resp_v)
    ,.resp_yumi_i (io_resp_yumi), .resp_op_o (io_resp_op), .resp_addr_o (io_resp_addr)
    ,.resp_data_o (io_resp_data), .resp_src_o (io_resp_src)
    );

  always #10 clk = ~clk;

  always @(negedge clk)
  begin
    if (mem_cmd_v && mem_cmd_ready)
      mem_log.push_back({mem_cmd_data, mem_cmd_src, mem_cmd_addr});
    if (io_cmd_v && io_cmd_ready)
      io_log.push_back({io_cmd_data, io_cmd_src, io_cmd_addr});
  end

  task automatic fail_run();
    $display(">>> FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("ERROR at %0t ns: %s, expected %h, got %h", $time, what, expected, actual);
      fail_run();
    end
  endtask

  task automatic timeout_abort(input string what);
    $display("Gave up after %0d cycles waiting for %s", TIMEOUT, what);
    fail_run();
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [63:0] random_bits(input int nbits);
    logic [63:0] w;
    w = '0;
    for (int i = 0; i < nbits; i++)
    begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[62:0], lfsr_state[0]};
    end
    return w;
  endfunction

  function automatic logic [ADDR_W-1:0] cfg_addr(input logic [1:0] idx);
    return (ADDR_W'(DEV_CFG) << DEV_LSB) | (ADDR_W'(idx) << CFG_REG_LSB);
  endfunction

  function automatic dest_e expected_dest(input logic [ADDR_W-1:0] addr);
    logic [3:0] dev;
    dev = addr[DEV_LSB +: 4];
    if (addr >= DRAM_BASE)
      return DEST_MEM;
    if (dev == DEV_CFG)
      return DEST_CFG;
    if ((dev == DEV_BOOT) || (dev == DEV_HOST))
      return DEST_IO;
    return DEST_LOOP;
  endfunction

  function automatic logic [DATA_W-1:0] expected_data(input mem_op_e op,
                                                      input logic [ADDR_W-1:0] addr);
    if (op == OP_WR)
      return '0;
    case (expected_dest(addr))
      DEST_CFG:          return cfg_model[addr[CFG_REG_LSB +: CFG_IDX_W]];
      DEST_IO, DEST_MEM: return DATA_W'(addr) ^ RESP_KEY;
      default:           return '0;
    endcase
  endfunction

  task automatic send_cmd(input int port, input mem_op_e op, input logic [ADDR_W-1:0] addr,
                          input logic [DATA_W-1:0] data);
    int waited;
    waited = 0;
    @(posedge clk);
    cmd_v[port]    <= 1'b1;
    cmd_op[port]   <= op;
    cmd_addr[port] <= addr;
    cmd_data[port] <= data;
    @(negedge clk);
    while (!cmd_ready[port])
    begin
      waited++;
      if (waited > TIMEOUT)
        timeout_abort("a command queue to accept");
      @(negedge clk);
    end
    @(posedge clk);
    cmd_v[port] <= 1'b0;
  endtask

  task automatic expect_resp(input int port, input mem_op_e op, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] data);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!resp_v[port])
    begin
      waited++;
      if (waited > TIMEOUT)
        timeout_abort("a response on a requester port");
      @(negedge clk);
    end
    check_value(64'(resp_op[port]), 64'(op), $sformatf("port %0d response opcode", port));
    check_value(64'(resp_addr[port]), 64'(addr), $sformatf("port %0d response address", port));
    check_value(resp_data[port], data, $sformatf("port %0d response data", port));
    @(posedge clk);
    resp_yumi[port] <= 1'b1;
    @(posedge clk);
    resp_yumi[port] <= 1'b0;
  endtask

  task automatic check_route(input int port, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] data);
    logic [DATA_W+SRC_W+ADDR_W-1:0] seen;
    dest_e                          dest;
    dest = expected_dest(addr);
    if ((dest == DEST_MEM) || (dest == DEST_IO))
    begin
      if ((dest == DEST_MEM) ? (mem_log.size() == 0) : (io_log.size() == 0))
      begin
        $display("No command reached the outgoing port for address %h", addr);
        fail_run();
      end
      seen = (dest == DEST_MEM) ? mem_log.pop_front() : io_log.pop_front();
      check_value(64'(seen[ADDR_W-1:0]), 64'(addr), "outgoing command address");
      check_value(64'(seen[ADDR_W +: SRC_W]), 64'(port), "outgoing source id");
      check_value(seen[ADDR_W+SRC_W +: DATA_W], data, "outgoing command data");
    end
  endtask

  task automatic check_logs_empty();
    check_value(64'(mem_log.size()), 64'(0), "extra commands on the memory port");
    check_value(64'(io_log.size()), 64'(0), "extra commands on the I/O port");
  endtask

  task automatic do_access(input int port, input mem_op_e op, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] wdata);
    logic [DATA_W-1:0] exp;
    exp = expected_data(op, addr);
    send_cmd(port, op, addr, wdata);
    expect_resp(port, op, addr, exp);
    if ((op == OP_WR) && (expected_dest(addr) == DEST_CFG))
      cfg_model[addr[CFG_REG_LSB +: CFG_IDX_W]] = wdata;
    check_route(port, addr, wdata);
    check_logs_empty();
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    check_value(64'(resp_v), 64'(0), "response valid after reset");
    check_value(64'(io_cmd_v), 64'(0), "I/O command valid after reset");
    check_value(64'(mem_cmd_v), 64'(0), "memory command valid after reset");
    for (int i = 0; i < CFG_NUM_REGS; i++)
      do_access(i % NUM_PORTS, OP_RD, cfg_addr(2'(i)), '0);
  endtask

  task automatic test_cfg_write_read();
    logic [1:0]        idx;
    logic [DATA_W-1:0] data;
    idx  = 2'(random_bits(2));
    data = random_bits(64);
    do_access(1, OP_WR, cfg_addr(idx), data);
    do_access(1, OP_RD, cfg_addr(idx), '0);
  endtask

  task automatic test_unmapped_read();
    do_access(2, OP_RD, (ADDR_W'(4'd5) << DEV_LSB) | ADDR_W'(random_bits(12) << 3),
              random_bits(64));
  endtask

  task automatic test_io_mem_routes();
    do_access(0, OP_RD, DRAM_BASE | ADDR_W'(random_bits(16) << 3), random_bits(64));
    do_access(1, OP_RD, (ADDR_W'(DEV_HOST) << DEV_LSB) | ADDR_W'(random_bits(12) << 3),
              random_bits(64));
  endtask

  task automatic test_mem_priority();
    logic [ADDR_W-1:0] a0, a2;
    a0 = DRAM_BASE | ADDR_W'(random_bits(16) << 3);
    a2 = a0 + 40'h100;
    fork
      send_cmd(0, OP_RD, a0, '0);
      send_cmd(2, OP_RD, a2, '0);
    join
    expect_resp(0, OP_RD, a0, expected_data(OP_RD, a0));
    expect_resp(2, OP_RD, a2, expected_data(OP_RD, a2));
    // Log order is dispatch order
    check_route(0, a0, '0);
    check_route(2, a2, '0);
    check_logs_empty();
  endtask

  task automatic test_mem_backpressure();
    logic [ADDR_W-1:0] maddr, caddr;
    logic [DATA_W-1:0] mexp, cexp;
    maddr = DRAM_BASE | ADDR_W'(random_bits(16) << 3);
    caddr = cfg_addr(2'(random_bits(2)));
    mexp  = expected_data(OP_RD, maddr);
    cexp  = expected_data(OP_RD, caddr);
    @(posedge clk);
    mem_cmd_ready <= 1'b0;
    send_cmd(0, OP_RD, maddr, '0);
    send_cmd(1, OP_RD, caddr, '0);
    repeat (20)
    begin
      @(negedge clk);
      check_value(64'(resp_v), 64'(0), "response while the memory port is stalled");
      check_value(64'(mem_cmd_v), 64'(0), "memory command while not ready");
    end
    @(posedge clk);
    mem_cmd_ready <= 1'b1;
    expect_resp(0, OP_RD, maddr, mexp);
    expect_resp(1, OP_RD, caddr, cexp);
    check_route(0, maddr, '0);
    check_logs_empty();
  endtask

  initial
  begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    cmd_v         = '0;
    cmd_addr      = '0;
    cmd_data      = '0;
    resp_yumi     = '0;
    io_cmd_ready  = 1'b1;
    mem_cmd_ready = 1'b1;
    lfsr_state    = 16'd62;
    for (int p = 0; p < NUM_PORTS; p++)
      cmd_op[p] = OP_RD;
    for (int r = 0; r < CFG_NUM_REGS; r++)
      cfg_model[r] = '0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    test_reset_state();
    test_cfg_write_read();
    test_unmapped_read();
    test_io_mem_routes();
    test_mem_priority();
    test_mem_backpressure();

    $display(">>> PASS");
    $finish;
  end

endmodule

// File: mem_xbar_top.f
mem_xbar_pkg.sv
two_entry_fifo.sv
cmd_dispatch.sv
resp_router.sv
cfg_regs.sv
loopback_dev.sv
mem_xbar_top.sv
tb_mem_xbar.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_mem_xbar
FILELIST  ?= mem_xbar_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and scan the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q ">>> PASS" $(LOG); then echo "Simulation ended without passing"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
